// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_fm_top
FLIST = compile.f

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: compile.f
fm_pkg.sv
fm_clk_div.sv
fm_mmr.sv
fm_param_store.sv
fm_timers.sv
fm_top.sv
fm_chk.sv
tb_fm_top.sv

// File: fm_chk.sv
/* decoder strobe checks */
`timescale 1ns/100ps

module fm_chk (
    input logic       clk,
    input logic       rst,
    input logic       wr,
    input logic [1:0] addr,
    input logic       pw_valid,
    input logic       kon_valid,
    input logic       busy
);

    int fails = 0;  // read by the testbench

    pw_one_cycle: assert property (@(posedge clk) disable iff (rst) pw_valid |=> !pw_valid)
        else begin
            fails++;
            $error("pw_valid high for more than one cycle");
        end

    kon_one_cycle: assert property (@(posedge clk) disable iff (rst) kon_valid |=> !kon_valid)
        else begin
            fails++;
            $error("kon_valid high for more than one cycle");
        end

    // data write sets busy on the next clk
    busy_rise: assert property (@(posedge clk) disable iff (rst) (wr && addr[0]) |=> busy)
        else begin
            fails++;
            $error("busy not set after a data write");
        end

endmodule

bind fm_mmr fm_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .addr      (addr),
    .pw_valid  (pw_valid),
    .kon_valid (kon_valid),
    .busy      (busy)
);

// File: fm_clk_div.sv
/* synth clock-enable prescaler */
`timescale 1ns/100ps

module fm_clk_div (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] div_sel,
    output logic       clk_en
);

    logic [2:0] cnt;
    logic [2:0] reload;

    // ratio minus one, picked up only when the counter reloads
    always_comb begin
        case (div_sel)
            fm_pkg::div_n3: reload = 3'd2;
            fm_pkg::div_n2: reload = 3'd1;
            default:        reload = 3'd5;  // divide by 6
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= 3'd0;
            clk_en <= 1'b0;
        end else if (cnt == 3'd0) begin
            cnt    <= reload;
            clk_en <= 1'b1;     // one clk wide
        end else begin
            cnt    <= cnt - 3'd1;
            clk_en <= 1'b0;
        end
    end

endmodule

// File: fm_mmr.sv
/* host register decoder */
`timescale 1ns/100ps

module fm_mmr (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    input  logic                wr,
    input  logic [1:0]          addr,
    input  logic [7:0]          din,
    output logic                busy,
    output logic [1:0]          div_sel,
    output fm_pkg::param_wr_t   pw,
    output logic                pw_valid,
    output logic                kon_valid,
    output logic [2:0]          kon_ch,
    output logic [3:0]          kon_mask,
    output fm_pkg::tmr_ctl_t    tc,
    output logic                eg_stop,
    output logic                pg_stop
);

    logic [7:0] sel_reg;    // last register number written
    logic       part;
    logic       addr_wr;
    logic       data_wr;
    logic       is_param;
    logic       is_kon;
    logic [2:0] grp;
    logic [2:0] ch_idx;
    logic [2:0] kon_idx;
    logic [4:0] busy_cnt;

    // part or high bit selects channels 4 to 6
    function automatic logic [2:0] chan_num(input logic hi, input logic [1:0] lo);
        chan_num = hi ? {1'b0, lo} + 3'd3 : {1'b0, lo};
    endfunction

    assign addr_wr = wr && !addr[0];
    assign data_wr = wr && addr[0];
    assign ch_idx  = chan_num(part, sel_reg[1:0]);
    assign kon_idx = chan_num(din[2], din[1:0]);
    assign is_kon  = sel_reg == fm_pkg::reg_kon && din[1:0] != 2'b11;

    always_comb begin
        grp      = fm_pkg::grp_dt_mul;
        is_param = 1'b0;
        case (sel_reg[7:4])
            4'h3: is_param = 1'b1;
            4'h4: begin
                grp      = fm_pkg::grp_tl;
                is_param = 1'b1;
            end
            4'h5: begin
                grp      = fm_pkg::grp_ks_ar;
                is_param = 1'b1;
            end
            4'hB: begin
                grp      = fm_pkg::grp_alg_fb;
                is_param = sel_reg[3:2] == 2'b00;   // b0h..b2h only
            end
            default: is_param = 1'b0;
        endcase
        if (sel_reg[1:0] == 2'b11)
            is_param = 1'b0;    // no channel behind xx3h
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg   <= 8'h00;
            part      <= 1'b0;
            div_sel   <= fm_pkg::div_n6;
            tc        <= '0;
            eg_stop   <= 1'b0;
            pg_stop   <= 1'b0;
            pw_valid  <= 1'b0;
            kon_valid <= 1'b0;
        end else begin
            pw_valid  <= data_wr && is_param;
            kon_valid <= data_wr && is_kon;
            if (addr_wr) begin
                sel_reg <= din;
                part    <= addr[1];
            end else if (data_wr) begin
                case (sel_reg)
                    fm_pkg::reg_testym: begin
                        eg_stop <= din[5];
                        pg_stop <= din[3];
                    end
                    fm_pkg::reg_clka1: tc.value_a[9:2] <= din;
                    fm_pkg::reg_clka2: tc.value_a[1:0] <= din[1:0];
                    fm_pkg::reg_clkb:  tc.value_b      <= din;
                    fm_pkg::reg_timer: begin
                        tc.load_a   <= din[0];
                        tc.load_b   <= din[1];
                        tc.irq_en_a <= din[2];
                        tc.irq_en_b <= din[3];
                        tc.clr_a    <= din[4];
                        tc.clr_b    <= din[5];
                    end
                    fm_pkg::reg_clk_n6: div_sel <= fm_pkg::div_n6;
                    fm_pkg::reg_clk_n3: div_sel <= fm_pkg::div_n3;
                    fm_pkg::reg_clk_n2: div_sel <= fm_pkg::div_n2;
                    default: ;
                endcase
            end else if (clk_en) begin
                tc.clr_a <= 1'b0;   // clear strobes drop on the next tick
                tc.clr_b <= 1'b0;
            end
        end
    end

    // write payload, qualified by pw_valid and kon_valid
    always_ff @(posedge clk) begin
        if (data_wr) begin
            pw.group <= grp;
            pw.ch    <= ch_idx;
            pw.op    <= sel_reg[3:2];
            pw.data  <= din;
            kon_ch   <= kon_idx;
            kon_mask <= din[7:4];
        end
    end

    // busy lasts 32 synth ticks from the last data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= 5'd0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= 5'd0;
        end else if (clk_en && busy) begin
            if (busy_cnt == 5'd31)
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 5'd1;
        end
    end

endmodule

// File: fm_param_store.sv
/* operator and channel parameter store */
`timescale 1ns/100ps

module fm_param_store (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    input  fm_pkg::param_wr_t   pw,
    input  logic                pw_valid,
    input  logic                kon_valid,
    input  logic [2:0]          kon_ch,
    input  logic [3:0]          kon_mask,
    output logic [4:0]          slot,
    output fm_pkg::slot_param_t slot_q
);

    logic [2:0] dt_mem  [fm_pkg::num_slot];
    logic [3:0] mul_mem [fm_pkg::num_slot];
    logic [6:0] tl_mem  [fm_pkg::num_slot];
    logic [1:0] ks_mem  [fm_pkg::num_slot];
    logic [4:0] ar_mem  [fm_pkg::num_slot];
    logic [2:0] alg_mem [fm_pkg::num_ch];
    logic [2:0] fb_mem  [fm_pkg::num_ch];
    logic [3:0] kon_mem [fm_pkg::num_ch];    // one bit per operator

    logic [4:0]          wslot;
    logic [4:0]          slot_nxt;
    fm_pkg::slot_param_t play;

    assign wslot    = {pw.ch, pw.op};   // ch*4 + op
    assign slot_nxt = (slot == 5'(fm_pkg::num_slot - 1)) ? 5'd0 : slot + 5'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fm_pkg::num_slot; i++) begin
                dt_mem[i]  <= 3'd0;
                mul_mem[i] <= 4'd0;
                tl_mem[i]  <= 7'd0;
                ks_mem[i]  <= 2'd0;
                ar_mem[i]  <= 5'd0;
            end
            for (int c = 0; c < fm_pkg::num_ch; c++) begin
                alg_mem[c] <= 3'd0;
                fb_mem[c]  <= 3'd0;
                kon_mem[c] <= 4'd0;
            end
        end else begin
            if (pw_valid) begin
                case (pw.group)
                    fm_pkg::grp_dt_mul: begin
                        dt_mem[wslot]  <= pw.data.dt_mul.dt;
                        mul_mem[wslot] <= pw.data.dt_mul.mul;
                    end
                    fm_pkg::grp_tl: tl_mem[wslot] <= pw.data[6:0];
                    fm_pkg::grp_ks_ar: begin
                        ks_mem[wslot] <= pw.data.ks_ar.ks;
                        ar_mem[wslot] <= pw.data.ks_ar.ar;
                    end
                    fm_pkg::grp_alg_fb: begin
                        fb_mem[pw.ch]  <= pw.data[5:3];
                        alg_mem[pw.ch] <= pw.data[2:0];
                    end
                    default: ;
                endcase
            end
            if (kon_valid)
                kon_mem[kon_ch] <= kon_mask;
        end
    end

    // merge slot and channel fields for the slot coming up
    always_comb begin
        play       = '0;
        play.dt    = dt_mem[slot_nxt];
        play.mul   = mul_mem[slot_nxt];
        play.tl    = tl_mem[slot_nxt];
        play.ks    = ks_mem[slot_nxt];
        play.ar    = ar_mem[slot_nxt];
        play.alg   = alg_mem[slot_nxt[4:2]];
        play.fb    = fb_mem[slot_nxt[4:2]];
        play.keyon = kon_mem[slot_nxt[4:2]][slot_nxt[1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot   <= 5'd0;
            slot_q <= '0;
        end else if (clk_en) begin
            slot   <= slot_nxt;
            slot_q <= play;     // same-cycle write still shows old data
        end
    end

endmodule

// File: fm_pkg.sv
/* fm synth control definitions */
package fm_pkg;

    // bank 0 global registers
    localparam logic [7:0] reg_testym = 8'h21;
    localparam logic [7:0] reg_clka1  = 8'h24;
    localparam logic [7:0] reg_clka2  = 8'h25;
    localparam logic [7:0] reg_clkb   = 8'h26;
    localparam logic [7:0] reg_timer  = 8'h27;
    localparam logic [7:0] reg_kon    = 8'h28;
    localparam logic [7:0] reg_clk_n6 = 8'h2D;
    localparam logic [7:0] reg_clk_n3 = 8'h2E;
    localparam logic [7:0] reg_clk_n2 = 8'h2F;

    localparam int num_ch   = 6;
    localparam int num_slot = 24;   // 4 operators per channel

    // prescaler ratio codes on div_sel
    localparam logic [1:0] div_n6 = 2'd3;
    localparam logic [1:0] div_n3 = 2'd1;
    localparam logic [1:0] div_n2 = 2'd0;

    // parameter write groups
    localparam logic [2:0] grp_dt_mul = 3'd0;   // 3xh
    localparam logic [2:0] grp_tl     = 3'd1;   // 4xh
    localparam logic [2:0] grp_ks_ar  = 3'd2;   // 5xh
    localparam logic [2:0] grp_alg_fb = 3'd3;   // b0h-b2h

    // one operator data byte, two decodings
    typedef union packed {
        struct packed {
            logic       pad;
            logic [2:0] dt;
            logic [3:0] mul;
        } dt_mul;
        struct packed {
            logic [1:0] ks;
            logic       pad;
            logic [4:0] ar;
        } ks_ar;
    } op_data_u;

    typedef struct packed {
        logic [2:0] group;
        logic [2:0] ch;     // 0..5, part 1 maps to 3..5
        logic [1:0] op;
        op_data_u   data;   // tl uses bits 6:0
    } param_wr_t;

    typedef struct packed {
        logic [2:0] dt;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic [2:0] alg;
        logic [2:0] fb;
        logic       keyon;
        logic [1:0] rsvd;
    } slot_param_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_a;
        logic       clr_b;
    } tmr_ctl_t;

endpackage

// File: fm_timers.sv
/* timer a and b with irq */
`timescale 1ns/100ps

module fm_timers (
    input  logic             clk,
    input  logic             rst,
    input  logic             clk_en,
    input  fm_pkg::tmr_ctl_t tc,
    output logic             flag_a,
    output logic             flag_b,
    output logic             irq
);

    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [3:0] pre_b;  // timer b ticks once per 16
    logic       ovf_a;
    logic       ovf_b;

    assign ovf_a = clk_en && tc.load_a && cnt_a == 10'h3ff;
    assign ovf_b = clk_en && tc.load_b && pre_b == 4'hf && cnt_b == 8'hff;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= 10'd0;
        end else if (!tc.load_a) begin
            cnt_a <= tc.value_a;    // held at start value while stopped
        end else if (clk_en) begin
            cnt_a <= ovf_a ? tc.value_a : cnt_a + 10'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b <= 8'd0;
            pre_b <= 4'd0;
        end else if (!tc.load_b) begin
            cnt_b <= tc.value_b;
            pre_b <= 4'd0;
        end else if (clk_en) begin
            pre_b <= pre_b + 4'd1;
            if (pre_b == 4'hf)
                cnt_b <= ovf_b ? tc.value_b : cnt_b + 8'd1;
        end
    end

    // sticky flags, clear wins over a new overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (tc.clr_a)
                flag_a <= 1'b0;
            else if (ovf_a && tc.irq_en_a)
                flag_a <= 1'b1;
            if (tc.clr_b)
                flag_b <= 1'b0;
            else if (ovf_b && tc.irq_en_b)
                flag_b <= 1'b1;
        end
    end

    assign irq = flag_a | flag_b;

endmodule

// File: fm_top.sv
/* fm synth host control top */
`timescale 1ns/100ps

module fm_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr,
    input  logic [1:0]          addr,
    input  logic [7:0]          din,
    output logic                busy,
    output logic                eg_stop,
    output logic                pg_stop,
    output logic [4:0]          slot,
    output fm_pkg::slot_param_t slot_q,
    output logic                flag_a,
    output logic                flag_b,
    output logic                irq
);

    logic              clk_en;
    logic [1:0]        div_sel;
    fm_pkg::param_wr_t pw;
    logic              pw_valid;
    logic              kon_valid;
    logic [2:0]        kon_ch;
    logic [3:0]        kon_mask;
    fm_pkg::tmr_ctl_t  tc;

    fm_clk_div u_div (
        .clk     (clk),
        .rst     (rst),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    fm_mmr u_mmr (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .wr        (wr),
        .addr      (addr),
        .din       (din),
        .busy      (busy),
        .div_sel   (div_sel),
        .pw        (pw),
        .pw_valid  (pw_valid),
        .kon_valid (kon_valid),
        .kon_ch    (kon_ch),
        .kon_mask  (kon_mask),
        .tc        (tc),
        .eg_stop   (eg_stop),
        .pg_stop   (pg_stop)
    );

    fm_param_store u_store (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .pw        (pw),
        .pw_valid  (pw_valid),
        .kon_valid (kon_valid),
        .kon_ch    (kon_ch),
        .kon_mask  (kon_mask),
        .slot      (slot),
        .slot_q    (slot_q)
    );

    fm_timers u_timers (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .tc     (tc),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq    (irq)
    );

endmodule

// File: tb_fm_top.sv
/* fm control testbench */
`timescale 1ns/100ps

module tb_fm_top;

    typedef struct packed {
        logic                part;
        logic [7:0]          regnum;
        logic [7:0]          data;
        logic [4:0]          target;    // slot to watch after the write
        fm_pkg::slot_param_t exp;
    } vec_t;

    logic                clk;
    logic                rst;
    logic                wr;
    logic [1:0]          addr;
    logic [7:0]          din;
    logic                busy;
    logic                eg_stop;
    logic                pg_stop;
    logic [4:0]          slot;
    fm_pkg::slot_param_t slot_q;
    logic                flag_a;
    logic                flag_b;
    logic                irq;

    integer              seed;
    fm_pkg::slot_param_t model [fm_pkg::num_slot];     // expected store contents
    vec_t                vecs [$];
    string               names [$];

    fm_top DUT (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .addr    (addr),
        .din     (din),
        .busy    (busy),
        .eg_stop (eg_stop),
        .pg_stop (pg_stop),
        .slot    (slot),
        .slot_q  (slot_q),
        .flag_a  (flag_a),
        .flag_b  (flag_b),
        .irq     (irq)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "stopping on first error");
    endtask

    // bound decoder checks count their failures
    always @(negedge clk) begin
        if (DUT.u_mmr.u_chk.fails != 0) begin
            $display("a decoder protocol assertion failed");
            stop_run();
        end
    end

    function automatic logic [7:0] rand_byte();
        rand_byte = 8'($random(seed));
    endfunction

    task automatic host_write(input logic [1:0] a, input logic [7:0] d);
        @(negedge clk);
        wr   = 1'b1;
        addr = a;
        din  = d;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic write_reg(input logic part, input logic [7:0] regnum, input logic [7:0] d);
        host_write({part, 1'b0}, regnum);
        host_write({part, 1'b1}, d);
    endtask

    // register map rules applied to the expected slot contents
    task automatic model_write(input logic part, input logic [7:0] regnum, input logic [7:0] d);
        int ch;
        int s;
        ch = (part ? 3 : 0) + int'(regnum[1:0]);
        s  = ch * 4 + int'(regnum[3:2]);
        if (regnum[1:0] != 2'b11) begin
            case (regnum[7:4])
                4'h3: begin
                    model[s].dt  = d[6:4];
                    model[s].mul = d[3:0];
                end
                4'h4: model[s].tl = d[6:0];
                4'h5: begin
                    model[s].ks = d[7:6];
                    model[s].ar = d[4:0];
                end
                4'hB: begin
                    if (regnum[3:2] == 2'b00) begin
                        for (int op = 0; op < 4; op++) begin
                            model[ch * 4 + op].alg = d[2:0];
                            model[ch * 4 + op].fb  = d[5:3];
                        end
                    end
                end
                default: ;
            endcase
        end
        if (regnum == 8'h28 && d[1:0] != 2'b11) begin
            ch = (d[2] ? 3 : 0) + int'(d[1:0]);     // key-on picks its own channel
            for (int op = 0; op < 4; op++)
                model[ch * 4 + op].keyon = d[4 + op];
        end
    endtask

    task automatic add_vec(input string name, input logic part, input logic [7:0] regnum,
                           input logic [7:0] d, input logic [4:0] target);
        vec_t v;
        model_write(part, regnum, d);
        v.part   = part;
        v.regnum = regnum;
        v.data   = d;
        v.target = target;
        v.exp    = model[target];
        vecs.push_back(v);
        names.push_back(name);
    endtask

    // wait until slot is (or is no longer) the target
    task automatic wait_slot(input logic [4:0] target, input bit want_eq);
        int cnt;
        cnt = 0;
        while ((slot == target) != want_eq) begin
            @(negedge clk);
            cnt++;
            if (cnt > 400) begin
                $display("timeout while waiting on slot %0d", target);
                stop_run();
            end
        end
    endtask

    task automatic slot_step(output int clks);
        logic [4:0] prev;
        prev = slot;
        clks = 0;
        do begin
            @(negedge clk);
            clks++;
            if (clks > 20) begin
                $display("timeout, slot stopped advancing");
                stop_run();
            end
        end while (slot == prev);
    endtask

    initial begin
        int cnt;
        seed = 32'hd3e1;
        clk  = 1'b0;
        rst  = 1'b1;
        wr   = 1'b0;
        addr = 2'b00;
        din  = 8'h00;
        for (int i = 0; i < fm_pkg::num_slot; i++)
            model[i] = '0;

        add_vec("dt_mul_ch0_op0", 1'b0, 8'h30, rand_byte(), 5'd0);
        add_vec("dt_mul_ch2_op3", 1'b0, 8'h3E, rand_byte(), 5'd11);
        add_vec("tl_ch1_op2", 1'b0, 8'h49, rand_byte(), 5'd6);
        add_vec("tl_ch4_op1", 1'b1, 8'h45, rand_byte(), 5'd17);
        add_vec("ks_ar_ch5_op3", 1'b1, 8'h5E, rand_byte(), 5'd23);
        add_vec("ks_ar_ch0_op0", 1'b0, 8'h50, rand_byte(), 5'd0);
        add_vec("dt_mul_ch3_op2", 1'b1, 8'h38, rand_byte(), 5'd14);
        add_vec("alg_fb_ch1", 1'b0, 8'hB1, rand_byte(), 5'd4);
        add_vec("ign_33_ch3_op0", 1'b0, 8'h33, rand_byte(), 5'd12);  // xx3h would alias ch3
        add_vec("ign_43_ch3_op0", 1'b0, 8'h43, rand_byte(), 5'd12);
        add_vec("ign_b3_ch3_op0", 1'b0, 8'hB3, rand_byte(), 5'd12);
        add_vec("alg_fb_ch5", 1'b1, 8'hB2, rand_byte(), 5'd20);
        add_vec("ign_5f_ch3_op3", 1'b0, 8'h5F, rand_byte(), 5'd15);
        add_vec("kon_ch4", 1'b0, 8'h28, 8'hA5, 5'd17);     // mask 1010
        add_vec("ign_3b_ch3_op2", 1'b0, 8'h3B, rand_byte(), 5'd14);
        add_vec("ign_4f_ch3_op3", 1'b0, 8'h4F, rand_byte(), 5'd15);
        add_vec("kon_ch0", 1'b0, 8'h28, 8'h30, 5'd0);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (vecs[i]) begin
            write_reg(vecs[i].part, vecs[i].regnum, vecs[i].data);
            repeat (2) @(negedge clk);  // store has taken the write
            wait_slot(vecs[i].target, 1'b0);
            wait_slot(vecs[i].target, 1'b1);
            assert (slot_q == vecs[i].exp) else begin
                $display("error: %s expected %h actual %h", names[i], vecs[i].exp, slot_q);
                stop_run();
            end
        end

        // busy from data writes only
        cnt = 0;
        while (busy) begin
            @(negedge clk);
            cnt++;
            if (cnt > 250) begin
                $display("timeout, busy never dropped after the table writes");
                stop_run();
            end
        end
        host_write(2'b00, fm_pkg::reg_testym);
        assert (!busy) else begin
            $display("error: busy_addr_write expected 0 actual %b", busy);
            stop_run();
        end
        host_write(2'b01, 8'h20);   // eg stop on, pg stop off
        assert (busy) else begin
            $display("error: busy_data_write expected 1 actual %b", busy);
            stop_run();
        end
        assert ({eg_stop, pg_stop} == 2'b10) else begin
            $display("error: test_reg_eg expected %b actual %b", 2'b10, {eg_stop, pg_stop});
            stop_run();
        end
        cnt = 0;
        while (busy) begin
            @(negedge clk);
            cnt++;
            if (cnt > 32 * 6 + 8) begin
                $display("timeout, busy still high after 32 ticks");
                stop_run();
            end
        end
        write_reg(1'b0, fm_pkg::reg_testym, 8'h08);
        assert ({eg_stop, pg_stop} == 2'b01) else begin
            $display("error: test_reg_pg expected %b actual %b", 2'b01, {eg_stop, pg_stop});
            stop_run();
        end

        // timer a from 1020 with irq enabled
        write_reg(1'b0, fm_pkg::reg_clka1, 8'hFF);
        write_reg(1'b0, fm_pkg::reg_clka2, 8'h00);
        write_reg(1'b0, fm_pkg::reg_timer, 8'h05);
        cnt = 0;
        while (!(flag_a && irq)) begin
            @(negedge clk);
            cnt++;
            if (cnt > 200) begin
                $display("timeout, timer a flag or irq never set");
                stop_run();
            end
        end
        write_reg(1'b0, fm_pkg::reg_timer, 8'h10);     // clear and stop
        cnt = 0;
        while (flag_a || irq) begin
            @(negedge clk);
            cnt++;
            if (cnt > 20) begin
                $display("timeout, timer a flag not cleared");
                stop_run();
            end
        end

        // timer b runs past overflow, irq disabled
        write_reg(1'b0, fm_pkg::reg_clkb, 8'hF0);
        write_reg(1'b0, fm_pkg::reg_timer, 8'h02);
        repeat (2000) begin
            @(negedge clk);
            assert (!flag_b && !irq) else begin
                $display("error: timer_b_no_irq expected 0 actual %b", flag_b | irq);
                stop_run();
            end
        end

        write_reg(1'b0, fm_pkg::reg_clk_n2, 8'h00);
        slot_step(cnt);
        slot_step(cnt);     // old ratio has run out
        repeat (4) begin
            slot_step(cnt);
            assert (cnt == 2) else begin
                $display("error: div_by_2 expected 2 actual %0d", cnt);
                stop_run();
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule
